/* hdl/slice_tx_gate.sv */
/* per-queue tx gate: override select, registered allowed
   and TSF capture at each window start */
`timescale 1ns/100ps

module slice_tx_gate (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic [xpu_pkg::NUM_SLICE-1:0]                slice_en_i,
    input  xpu_pkg::tx_override_t                        tx_override_i,
    input  xpu_pkg::tsf_t                                tsf_i,
    output logic [xpu_pkg::NUM_SLICE-1:0]                high_tx_allowed_o,
    output xpu_pkg::reg_data_t [xpu_pkg::NUM_SLICE-1:0]  capt_o
);

    logic [xpu_pkg::NUM_SLICE-1:0] allowed_q;
    logic [xpu_pkg::NUM_SLICE-1:0] en_d;
    logic [xpu_pkg::NUM_SLICE-1:0] rise_q;
    xpu_pkg::reg_data_t [xpu_pkg::NUM_SLICE-1:0] capt_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            allowed_q <= '0;
            en_d      <= '0;
            rise_q    <= '0;
        end else begin
            // override value where enabled, slice window elsewhere
            allowed_q <= (tx_override_i.en & tx_override_i.val) |
                         (~tx_override_i.en & slice_en_i);
            en_d      <= slice_en_i;
            // window start, one cycle wide
            rise_q    <= slice_en_i & ~en_d;
        end
    end

    // low TSF word latched per queue on window start
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            capt_q <= '0;
        end else begin
            for (int i = 0; i < xpu_pkg::NUM_SLICE; i++) begin
                if (rise_q[i]) begin
                    capt_q[i] <= tsf_i[xpu_pkg::REG_DATA_W-1:0];
                end
            end
        end
    end

    assign high_tx_allowed_o = allowed_q;
    assign capt_o            = capt_q;

endmodule

/* hdl/time_slice.sv */
/* one TDMA slice: wrapping microsecond counter
   and its registered enable window */
`timescale 1ns/100ps

module time_slice (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                tsf_pulse_1M_i,
    input  xpu_pkg::slice_cfg_t cfg_i,
    input  logic                restart_i,
    output logic                slice_en_o
);

    xpu_pkg::slice_cnt_t cnt_q;
    xpu_pkg::slice_cnt_t cnt_nxt;
    logic at_last;
    logic en_nxt;
    logic en_q;

    // end of period, also catches a total lowered below the count
    assign at_last = (cfg_i.total == '0) || (cnt_q >= cfg_i.total - 1'b1);

    // count advances on the tick, restart goes back to zero
    always_comb begin
        cnt_nxt = cnt_q;
        if (restart_i) begin
            cnt_nxt = '0;
        end else if (tsf_pulse_1M_i) begin
            cnt_nxt = at_last ? '0 : cnt_q + 1'b1;
        end
    end

    // window is start <= count < end
    // zero total means slice off
    assign en_nxt = (cfg_i.total != '0) &&
                    (cnt_nxt >= cfg_i.start) &&
                    (cnt_nxt < cfg_i.stop);

    // enable moves with the count, one cycle after the tick
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            en_q  <= 1'b0;
        end else begin
            cnt_q <= cnt_nxt;
            en_q  <= en_nxt;
        end
    end

    assign slice_en_o = en_q;

endmodule

/* hdl/tsf_timer.sv */
/* 64-bit microsecond TSF timer with prescaler,
   1 MHz tick and load from the register bank */
`timescale 1ns/100ps

module tsf_timer (
    input  logic               clk,
    input  logic               rst_n_i,
    input  xpu_pkg::tsf_load_t tsf_load_i,
    output xpu_pkg::tsf_t      tsf_o,
    output logic               tsf_pulse_1M_o
);

    xpu_pkg::presc_cnt_t presc_q;
    logic presc_wrap;
    logic pulse_q;
    xpu_pkg::tsf_t tsf_q;

    // last cycle of each microsecond
    assign presc_wrap = (presc_q == xpu_pkg::presc_cnt_t'(xpu_pkg::CLKS_PER_US - 1));

    // free running prescaler, pulse is one cycle wide
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            presc_q <= '0;
            pulse_q <= 1'b0;
        end else begin
            presc_q <= presc_wrap ? '0 : presc_q + 1'b1;
            pulse_q <= presc_wrap;
        end
    end

    // load wins over the tick
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tsf_q <= '0;
        end else if (tsf_load_i.strobe) begin
            tsf_q <= tsf_load_i.value;
        end else if (pulse_q) begin
            tsf_q <= tsf_q + 1'b1;
        end
    end

    assign tsf_o          = tsf_q;
    assign tsf_pulse_1M_o = pulse_q;

endmodule

/* hdl/xpu_pkg.sv */
/* TDMA timing block shared definitions: widths, register map,
   typedefs and the structs passed between the bank, timer, slices and gate */
package xpu_pkg;

    // one slice per transmit queue
    localparam int NUM_SLICE = 4;
    // 100 MHz clock, so 100 cycles per microsecond tick
    localparam int CLKS_PER_US = 100;
    localparam int PRESC_W = $clog2(CLKS_PER_US);

    // register port widths
    localparam int REG_ADDR_W = 6;
    localparam int REG_DATA_W = 32;

    // 802.11 TSF is 64 bits of microseconds
    localparam int TSF_W = 64;
    localparam int SLICE_CNT_W = 20;

    // slice index sits just above the count field
    localparam int SLICE_IDX_LSB = 20;
    localparam int SLICE_IDX_W = $clog2(NUM_SLICE);

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;
    typedef logic [TSF_W-1:0] tsf_t;
    typedef logic [SLICE_CNT_W-1:0] slice_cnt_t;
    typedef logic [SLICE_IDX_W-1:0] slice_idx_t;
    typedef logic [PRESC_W-1:0] presc_cnt_t;

    // register map
    localparam reg_addr_t REG_CTRL = 6'd1;
    localparam reg_addr_t REG_TSF_LD_LO = 6'd2;
    localparam reg_addr_t REG_TSF_LD_HI = 6'd3;
    localparam reg_addr_t REG_SLICE_TOTAL = 6'd20;
    localparam reg_addr_t REG_SLICE_START = 6'd21;
    localparam reg_addr_t REG_SLICE_END = 6'd22;
    // four consecutive capture words
    localparam reg_addr_t REG_CAPT_BASE = 6'd40;
    localparam reg_addr_t REG_TSF_RD_LO = 6'd58;
    localparam reg_addr_t REG_TSF_RD_HI = 6'd59;

    // REG_CTRL layout, one byte per queue
    localparam int OVR_STRIDE = 8;
    localparam int OVR_VAL_BIT = 0;
    localparam int OVR_EN_BIT = 4;
    // msb of the high load word, rising edge loads the timer
    localparam int TSF_LD_TRIG_BIT = 31;

    // window of one slice, all in microseconds
    typedef struct packed {
        slice_cnt_t total;
        slice_cnt_t start;
        slice_cnt_t stop;
    } slice_cfg_t;

    // software override per queue
    typedef struct packed {
        logic [NUM_SLICE-1:0] en;
        logic [NUM_SLICE-1:0] val;
    } tx_override_t;

    // load request toward the timer
    typedef struct packed {
        logic strobe;
        tsf_t value;
    } tsf_load_t;

endpackage

/* hdl/xpu_reg_bank.sv */
/* register bank: write decode, slice config routing, override bits,
   TSF load edge detect and the registered readback mux */
`timescale 1ns/100ps

module xpu_reg_bank (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          reg_wr_en_i,
    input  xpu_pkg::reg_addr_t                            reg_addr_i,
    input  xpu_pkg::reg_data_t                            reg_wdata_i,
    input  logic                                          rd_en_i,
    input  xpu_pkg::reg_addr_t                            rd_addr_i,
    input  xpu_pkg::tsf_t                                 tsf_i,
    input  xpu_pkg::reg_data_t [xpu_pkg::NUM_SLICE-1:0]   capt_i,
    output xpu_pkg::tsf_load_t                            tsf_load_o,
    output xpu_pkg::slice_cfg_t [xpu_pkg::NUM_SLICE-1:0]  slice_cfg_o,
    output logic                                          slice_restart_o,
    output xpu_pkg::tx_override_t                         tx_override_o,
    output xpu_pkg::reg_data_t                            rd_data_o,
    output logic                                          rd_valid_o
);

    xpu_pkg::reg_data_t ctrl_q;
    xpu_pkg::reg_data_t tsf_ld_lo_q;
    xpu_pkg::reg_data_t tsf_ld_hi_q;
    // last written words of the slice registers
    xpu_pkg::reg_data_t slice_total_q;
    xpu_pkg::reg_data_t slice_start_q;
    xpu_pkg::reg_data_t slice_stop_q;
    xpu_pkg::slice_cfg_t [xpu_pkg::NUM_SLICE-1:0] cfg_q;

    logic ld_trig_d;
    logic ld_strobe_q;
    logic restart_q;
    logic slice_wr;
    xpu_pkg::slice_idx_t wr_idx;
    xpu_pkg::slice_cnt_t wr_cnt;

    xpu_pkg::reg_data_t rd_mux;
    xpu_pkg::reg_data_t rd_data_q;
    logic rd_valid_q;

    // index and count fields of a slice write
    assign wr_idx = reg_wdata_i[xpu_pkg::SLICE_IDX_LSB +: xpu_pkg::SLICE_IDX_W];
    assign wr_cnt = reg_wdata_i[xpu_pkg::SLICE_CNT_W-1:0];
    assign slice_wr = reg_wr_en_i && ((reg_addr_i == xpu_pkg::REG_SLICE_TOTAL) ||
                                      (reg_addr_i == xpu_pkg::REG_SLICE_START) ||
                                      (reg_addr_i == xpu_pkg::REG_SLICE_END));

    // register writes, one per strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q        <= '0;
            tsf_ld_lo_q   <= '0;
            tsf_ld_hi_q   <= '0;
            slice_total_q <= '0;
            slice_start_q <= '0;
            slice_stop_q  <= '0;
            cfg_q         <= '0;
        end else if (reg_wr_en_i) begin
            case (reg_addr_i)
                xpu_pkg::REG_CTRL: ctrl_q <= reg_wdata_i;
                xpu_pkg::REG_TSF_LD_LO: tsf_ld_lo_q <= reg_wdata_i;
                xpu_pkg::REG_TSF_LD_HI: tsf_ld_hi_q <= reg_wdata_i;
                xpu_pkg::REG_SLICE_TOTAL: begin
                    slice_total_q <= reg_wdata_i;
                    cfg_q[wr_idx].total <= wr_cnt;
                end
                xpu_pkg::REG_SLICE_START: begin
                    slice_start_q <= reg_wdata_i;
                    cfg_q[wr_idx].start <= wr_cnt;
                end
                xpu_pkg::REG_SLICE_END: begin
                    slice_stop_q <= reg_wdata_i;
                    cfg_q[wr_idx].stop <= wr_cnt;
                end
                default: ;
            endcase
        end
    end

    // load trigger edge and slice restart pulse
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ld_trig_d   <= 1'b0;
            ld_strobe_q <= 1'b0;
            restart_q   <= 1'b0;
        end else begin
            ld_trig_d   <= tsf_ld_hi_q[xpu_pkg::TSF_LD_TRIG_BIT];
            // one cycle on 0 -> 1 of the trigger bit
            ld_strobe_q <= tsf_ld_hi_q[xpu_pkg::TSF_LD_TRIG_BIT] & ~ld_trig_d;
            restart_q   <= slice_wr;
        end
    end

    // byte i of ctrl holds enable and value of queue i
    always_comb begin
        for (int i = 0; i < xpu_pkg::NUM_SLICE; i++) begin
            tx_override_o.en[i]  = ctrl_q[i*xpu_pkg::OVR_STRIDE + xpu_pkg::OVR_EN_BIT];
            tx_override_o.val[i] = ctrl_q[i*xpu_pkg::OVR_STRIDE + xpu_pkg::OVR_VAL_BIT];
        end
    end

    // readback select, unmapped reads zero
    always_comb begin
        case (rd_addr_i)
            xpu_pkg::REG_CTRL: rd_mux = ctrl_q;
            xpu_pkg::REG_TSF_LD_LO: rd_mux = tsf_ld_lo_q;
            xpu_pkg::REG_TSF_LD_HI: rd_mux = tsf_ld_hi_q;
            xpu_pkg::REG_SLICE_TOTAL: rd_mux = slice_total_q;
            xpu_pkg::REG_SLICE_START: rd_mux = slice_start_q;
            xpu_pkg::REG_SLICE_END: rd_mux = slice_stop_q;
            xpu_pkg::REG_TSF_RD_LO: rd_mux = tsf_i[xpu_pkg::REG_DATA_W-1:0];
            xpu_pkg::REG_TSF_RD_HI: rd_mux = tsf_i[xpu_pkg::TSF_W-1:xpu_pkg::REG_DATA_W];
            default: rd_mux = '0;
        endcase
        // capture words follow the base address
        for (int i = 0; i < xpu_pkg::NUM_SLICE; i++) begin
            if (rd_addr_i == xpu_pkg::REG_CAPT_BASE + xpu_pkg::reg_addr_t'(i)) begin
                rd_mux = capt_i[i];
            end
        end
    end

    // read data and valid one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_q <= rd_mux;
        end
    end

    assign tsf_load_o.strobe = ld_strobe_q;
    assign tsf_load_o.value  = {tsf_ld_hi_q, tsf_ld_lo_q};
    assign slice_cfg_o       = cfg_q;
    assign slice_restart_o   = restart_q;
    assign rd_data_o         = rd_data_q;
    assign rd_valid_o        = rd_valid_q;

endmodule

/* hdl/xpu_tdma.sv */
/* TDMA timing top: register bank, TSF timer,
   one time slice per queue and the tx gate */
`timescale 1ns/100ps

module xpu_tdma (
    input  logic                          clk,
    input  logic                          rst_n_i,
    // register write port
    input  logic                          reg_wr_en_i,
    input  xpu_pkg::reg_addr_t            reg_addr_i,
    input  xpu_pkg::reg_data_t            reg_wdata_i,
    // register read port
    input  logic                          rd_en_i,
    input  xpu_pkg::reg_addr_t            rd_addr_i,
    output xpu_pkg::reg_data_t            rd_data_o,
    output logic                          rd_valid_o,
    // timing outputs
    output xpu_pkg::tsf_t                 tsf_runtime_val_o,
    output logic                          tsf_pulse_1M_o,
    output logic [xpu_pkg::NUM_SLICE-1:0] high_tx_allowed_o
);

    xpu_pkg::tsf_load_t tsf_load;
    xpu_pkg::slice_cfg_t [xpu_pkg::NUM_SLICE-1:0] slice_cfg;
    logic slice_restart;
    xpu_pkg::tx_override_t tx_override;
    xpu_pkg::tsf_t tsf;
    logic tsf_pulse;
    logic [xpu_pkg::NUM_SLICE-1:0] slice_en;
    xpu_pkg::reg_data_t [xpu_pkg::NUM_SLICE-1:0] capt;

    xpu_reg_bank u_reg_bank (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .reg_wr_en_i    (reg_wr_en_i),
        .reg_addr_i     (reg_addr_i),
        .reg_wdata_i    (reg_wdata_i),
        .rd_en_i        (rd_en_i),
        .rd_addr_i      (rd_addr_i),
        .tsf_i          (tsf),
        .capt_i         (capt),
        .tsf_load_o     (tsf_load),
        .slice_cfg_o    (slice_cfg),
        .slice_restart_o(slice_restart),
        .tx_override_o  (tx_override),
        .rd_data_o      (rd_data_o),
        .rd_valid_o     (rd_valid_o)
    );

    tsf_timer u_tsf_timer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .tsf_load_i    (tsf_load),
        .tsf_o         (tsf),
        .tsf_pulse_1M_o(tsf_pulse)
    );

    // one slice per queue, all restarted together
    for (genvar i = 0; i < xpu_pkg::NUM_SLICE; i++) begin : g_slice
        time_slice u_time_slice (
            .clk           (clk),
            .rst_n_i       (rst_n_i),
            .tsf_pulse_1M_i(tsf_pulse),
            .cfg_i         (slice_cfg[i]),
            .restart_i     (slice_restart),
            .slice_en_o    (slice_en[i])
        );
    end

    slice_tx_gate u_slice_tx_gate (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .slice_en_i       (slice_en),
        .tx_override_i    (tx_override),
        .tsf_i            (tsf),
        .high_tx_allowed_o(high_tx_allowed_o),
        .capt_o           (capt)
    );

    assign tsf_runtime_val_o = tsf;
    assign tsf_pulse_1M_o    = tsf_pulse;

endmodule

/* run_sim.sh */
#!/bin/sh
# build the TDMA testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_xpu_tdma -o sim_tdma -f verilog.f || exit 1
out=$(./obj_dir/sim_tdma 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'all tests passed' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_xpu_tdma.sv */
/* testbench for the TDMA timing top: clock, reset, register stimulus,
   reference functions for TSF and slice windows, compare tasks */
`timescale 1ns/100ps

module tb_xpu_tdma;

    logic clk;
    logic rst_n_i;
    logic reg_wr_en_i;
    xpu_pkg::reg_addr_t reg_addr_i;
    xpu_pkg::reg_data_t reg_wdata_i;
    logic rd_en_i;
    xpu_pkg::reg_addr_t rd_addr_i;
    xpu_pkg::reg_data_t rd_data_o;
    logic rd_valid_o;
    xpu_pkg::tsf_t tsf_runtime_val_o;
    logic tsf_pulse_1M_o;
    logic [xpu_pkg::NUM_SLICE-1:0] high_tx_allowed_o;

    // slice setup shared by the window tests
    int slice_total;
    int win_start[xpu_pkg::NUM_SLICE];
    int win_stop[xpu_pkg::NUM_SLICE];
    int high_cnt[xpu_pkg::NUM_SLICE];
    int pulse_cnt = 0;
    int cyc = 0;
    logic excl_check = 1'b0;

    xpu_tdma uut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc++;
    end

    // ticks seen, sampled away from the edge
    always @(negedge clk) begin
        if (tsf_pulse_1M_o) begin
            pulse_cnt++;
        end
    end

    // windows must never overlap
    always @(negedge clk) begin
        if (excl_check && $countones(high_tx_allowed_o) > 1) begin
            report_mismatch($sformatf("two queues allowed at once: %b", high_tx_allowed_o));
        end
    end

    // expected TSF after n ticks
    function automatic xpu_pkg::tsf_t tsf_after(xpu_pkg::tsf_t start, int unsigned n);
        return start + xpu_pkg::tsf_t'(n);
    endfunction

    // ticks with the window open over some periods
    function automatic int window_pulses(int start, int stop, int total, int periods);
        int hits;
        hits = 0;
        for (int c = 0; c < total; c++) begin
            if (c >= start && c < stop) begin
                hits++;
            end
        end
        return hits * periods;
    endfunction

    function automatic xpu_pkg::reg_data_t slice_word(int idx, int cnt);
        return (xpu_pkg::reg_data_t'(idx) << 20) | xpu_pkg::reg_data_t'(cnt);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("timeout: %s", msg);
        $display("tests failed");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic check_tsf(input xpu_pkg::tsf_t got, input xpu_pkg::tsf_t exp,
                             input xpu_pkg::tsf_t tol, input string what);
        if ($isunknown(got) || got > exp + tol || got + tol < exp) begin
            report_mismatch($sformatf("%s: got %0h, expected %0h", what, got, exp));
        end
    endtask

    task automatic check_data(input xpu_pkg::reg_data_t got, input xpu_pkg::reg_data_t exp,
                              input xpu_pkg::reg_data_t tol, input string what);
        if ($isunknown(got) || got > exp + tol || got + tol < exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_allowed(input logic [xpu_pkg::NUM_SLICE-1:0] got,
                                 input logic [xpu_pkg::NUM_SLICE-1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic drive_edge;
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input xpu_pkg::reg_addr_t addr, input xpu_pkg::reg_data_t data);
        drive_edge();
        reg_wr_en_i = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        drive_edge();
        reg_wr_en_i = 1'b0;
    endtask

    task automatic reg_read(input xpu_pkg::reg_addr_t addr, output xpu_pkg::reg_data_t data);
        int n;
        n = 0;
        drive_edge();
        rd_en_i   = 1'b1;
        rd_addr_i = addr;
        drive_edge();
        rd_en_i = 1'b0;
        while (!rd_valid_o) begin
            if (n > 4) begin
                report_timeout($sformatf("no read valid for address %0d", addr));
            end
            n++;
            drive_edge();
        end
        data = rd_data_o;
    endtask

    task automatic read_tsf(output xpu_pkg::tsf_t value);
        xpu_pkg::reg_data_t lo;
        xpu_pkg::reg_data_t hi;
        reg_read(xpu_pkg::REG_TSF_RD_LO, lo);
        reg_read(xpu_pkg::REG_TSF_RD_HI, hi);
        value = {hi, lo};
    endtask

    // next tick, never the one already seen
    task automatic wait_pulse;
        int n;
        n = 0;
        @(negedge clk);
        while (!tsf_pulse_1M_o) begin
            if (n > 2 * xpu_pkg::CLKS_PER_US) begin
                report_timeout("no 1 MHz pulse");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_allowed_rise(input int q);
        int n;
        n = 0;
        @(negedge clk);
        while (high_tx_allowed_o[q]) begin
            if (n > 2 * slice_total * xpu_pkg::CLKS_PER_US) begin
                report_timeout($sformatf("queue %0d allowed never drops", q));
            end
            n++;
            @(negedge clk);
        end
        n = 0;
        while (!high_tx_allowed_o[q]) begin
            if (n > 2 * slice_total * xpu_pkg::CLKS_PER_US) begin
                report_timeout($sformatf("queue %0d allowed never rises", q));
            end
            n++;
            @(negedge clk);
        end
    endtask

    // count allowed per tick, overridden queues checked on every tick
    task automatic run_pulses(input int n, input logic [xpu_pkg::NUM_SLICE-1:0] en,
                              input logic [xpu_pkg::NUM_SLICE-1:0] val);
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            high_cnt[q] = 0;
        end
        for (int p = 0; p < n; p++) begin
            wait_pulse();
            check_allowed(high_tx_allowed_o & en, val & en, "overridden queues");
            for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
                if (high_tx_allowed_o[q]) begin
                    high_cnt[q]++;
                end
            end
        end
    endtask

    initial begin
        xpu_pkg::tsf_t got_tsf;
        xpu_pkg::tsf_t load_val;
        xpu_pkg::reg_data_t capt_a;
        xpu_pkg::reg_data_t capt_b;
        xpu_pkg::reg_data_t ctrl_word;
        logic [xpu_pkg::NUM_SLICE-1:0] ovr_en;
        logic [xpu_pkg::NUM_SLICE-1:0] ovr_val;
        int pc0;
        int c0;
        int exp_cnt;
        void'($urandom(42));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        reg_wr_en_i = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        rd_en_i     = 1'b0;
        rd_addr_i   = '0;
        // four disjoint windows of different length in 40 us
        slice_total = 40;
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            win_start[q] = 10 * q;
            win_stop[q]  = 10 * q + 5 + q;
        end

        // reset and the quiet outputs
        repeat (8) begin
            drive_edge();
            check_allowed(high_tx_allowed_o, '0, "allowed in reset");
            check_data(xpu_pkg::reg_data_t'(tsf_pulse_1M_o), 0, 0, "pulse in reset");
            check_tsf(tsf_runtime_val_o, '0, '0, "TSF output in reset");
        end
        rst_n_i = 1'b1;
        drive_edge();
        check_allowed(high_tx_allowed_o, '0, "allowed after reset");
        check_data(xpu_pkg::reg_data_t'(tsf_pulse_1M_o), 0, 0, "pulse after reset");
        read_tsf(got_tsf);
        check_tsf(got_tsf, tsf_after(0, 0), 1, "first TSF read");

        // tick spacing
        for (int g = 0; g < 3; g++) begin
            wait_pulse();
            c0 = cyc;
            wait_pulse();
            check_data(xpu_pkg::reg_data_t'(cyc - c0), xpu_pkg::CLKS_PER_US, 0, "pulse gap");
        end

        // load, let a few ticks pass, read back
        load_val = {1'b1, 31'($urandom()), 32'($urandom())};
        reg_write(xpu_pkg::REG_TSF_LD_LO, load_val[31:0]);
        reg_write(xpu_pkg::REG_TSF_LD_HI, load_val[63:32]);
        pc0 = pulse_cnt;
        repeat (3) wait_pulse();
        read_tsf(got_tsf);
        check_tsf(got_tsf, tsf_after(load_val, pulse_cnt - pc0), 1, "TSF after load");
        // runtime output carries the same count
        check_tsf(tsf_runtime_val_o, tsf_after(load_val, pulse_cnt - pc0), 1,
                  "TSF output after load");

        // slice windows over 5 periods
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            reg_write(xpu_pkg::REG_SLICE_TOTAL, slice_word(q, slice_total));
            reg_write(xpu_pkg::REG_SLICE_START, slice_word(q, win_start[q]));
            reg_write(xpu_pkg::REG_SLICE_END, slice_word(q, win_stop[q]));
        end
        excl_check = 1'b1;
        run_pulses(5 * slice_total, '0, '0);
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            exp_cnt = window_pulses(win_start[q], win_stop[q], slice_total, 5);
            check_data(high_cnt[q], exp_cnt, 1, $sformatf("queue %0d window ticks", q));
        end

        // window start captures one period apart
        wait_allowed_rise(2);
        reg_read(xpu_pkg::REG_CAPT_BASE + 6'd2, capt_a);
        wait_allowed_rise(2);
        reg_read(xpu_pkg::REG_CAPT_BASE + 6'd2, capt_b);
        check_data(capt_b - capt_a, slice_total, 0, "capture step");
        excl_check = 1'b0;

        // random override, the rest keep their windows
        ovr_en    = 4'($urandom_range(15, 1));
        ovr_val   = 4'($urandom());
        ctrl_word = '0;
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            ctrl_word[q * 8 + 4] = ovr_en[q];
            ctrl_word[q * 8]     = ovr_val[q];
        end
        reg_write(xpu_pkg::REG_CTRL, ctrl_word);
        drive_edge();
        drive_edge();
        check_allowed(high_tx_allowed_o & ovr_en, ovr_val & ovr_en, "override applied");
        run_pulses(slice_total, ovr_en, ovr_val);
        for (int q = 0; q < xpu_pkg::NUM_SLICE; q++) begin
            if (ovr_en[q]) begin
                exp_cnt = ovr_val[q] ? slice_total : 0;
            end else begin
                exp_cnt = window_pulses(win_start[q], win_stop[q], slice_total, 1);
            end
            check_data(high_cnt[q], exp_cnt, 1, $sformatf("queue %0d with override", q));
        end

        if (uut.u_checker.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", uut.u_checker.fail_cnt);
            $display("tests failed");
            $fatal(1, "stopped on assertion failures");
        end
    end

endmodule

/* testbench/xpu_tdma_checker.sv */
/* concurrent assertions on the TDMA top level,
   bound into every xpu_tdma instance */
`timescale 1ns/100ps

module xpu_tdma_checker (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          tsf_pulse_1M_o,
    input logic                          rd_en_i,
    input logic                          rd_valid_o,
    input logic [xpu_pkg::NUM_SLICE-1:0] high_tx_allowed_o
);

    // failed assertions so far, read by the testbench at the end
    int fail_cnt = 0;

    // 1 MHz tick is a single cycle wide
    pulse_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        tsf_pulse_1M_o |=> !tsf_pulse_1M_o)
    else begin
        $error("1 MHz pulse high on two cycles in a row");
        fail_cnt++;
    end

    // no queue may send while held in reset
    allowed_in_reset: assert property (@(posedge clk)
        !rst_n_i |=> (high_tx_allowed_o == '0))
    else begin
        $error("tx allowed while reset is active");
        fail_cnt++;
    end

    // read valid is the read strobe delayed by one cycle
    rd_valid_after_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_en_i |=> rd_valid_o)
    else begin
        $error("read valid missing one cycle after the read strobe");
        fail_cnt++;
    end

    rd_valid_no_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        !rd_en_i |=> !rd_valid_o)
    else begin
        $error("read valid without a read strobe");
        fail_cnt++;
    end

endmodule

bind xpu_tdma xpu_tdma_checker u_checker (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .tsf_pulse_1M_o   (tsf_pulse_1M_o),
    .rd_en_i          (rd_en_i),
    .rd_valid_o       (rd_valid_o),
    .high_tx_allowed_o(high_tx_allowed_o)
);

/* verilog.f */
hdl/xpu_pkg.sv
hdl/tsf_timer.sv
hdl/time_slice.sv
hdl/slice_tx_gate.sv
hdl/xpu_reg_bank.sv
hdl/xpu_tdma.sv
testbench/xpu_tdma_checker.sv
testbench/tb_xpu_tdma.sv
